// ==== img2col_trace.txt ====
# w adr count data... writes count words from adr up, r adr expected reads and compares
# p polls status until done, all numbers hex except count
r 41 00000000
r 42 00000000
w 7f 1 12345678
r 7f 00000000
w 20 25 01 01 01 01 01 02 02 02 02 02 03 03 03 03 03 04 04 04 04 04 05 05 05 05 05
r 20 00000001
r 38 00000005
w 40 1 3
w 00 25 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19
p
r 42 000004c9
r 41 00000000
w 14 5 1a 1b 1c 1d 1e
p
r 42 00000640
w 14 5 1f 20 21 22 23
p
r 42 000007b7
w 40 1 2
w 00 25 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
p
r 42 00002580
w 14 5 ff ff ff ff ff
p
r 42 000031e7
w 20 25 ff ff ff ff ff fe fe fe fe fe fd fd fd fd fd fc fc fc fc fc fb fb fb fb fb
r 2a fffffffd
w 40 1 2
w 00 25 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19
p
r 42 fffffb37
r 41 00000000

// ==== img2col_top.f ====
img2col_pkg.sv
pixel_loader.sv
window_ctrl.sv
window_mac.sv
img2col_top.sv
img2col_chk.sv
img2col_tb.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv)

obj_dir/Vimg2col_tb: img2col_top.f $(SRCS)
	verilator --binary --timing --assert --top-module img2col_tb -f img2col_top.f

.PHONY: run clean

run: obj_dir/Vimg2col_tb img2col_trace.txt
	./obj_dir/Vimg2col_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== img2col_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module img2col_tb;

    localparam int reset_cycles  = 4;
    localparam int access_budget = 6;      // One access takes three cycles.
    localparam int poll_budget   = 64;

    logic                          clk;
    logic                          nrst;
    img2col_pkg::wb_req_t          wb_req;
    img2col_pkg::wb_rsp_t          wb_rsp;
    int                            cycles = 0;
    int                            cycle_limit;

    img2col_top UUT (
        .clk    (clk),
        .nrst   (nrst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // The limit grows by the budget of each trace line before it runs.
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: the run passed its limit of %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // The bound checker counts its failing assertions.
    always @(negedge clk)
    begin
        if (UUT.u_loader.u_chk.fail_count != 0)
        begin
            $display("An assertion in the bound checker failed");
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // Performs one Wishbone classic cycle and holds the strobe over the edge that samples ack.
    task automatic bus_access(
        input  logic                          we,
        input  logic [img2col_pkg::adr_w-1:0] adr,
        input  logic [img2col_pkg::dat_w-1:0] wdat,
        output logic [img2col_pkg::dat_w-1:0] rdat
    );
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk);
        while (!wb_rsp.ack)
        begin
            @(negedge clk);
        end
        rdat = wb_rsp.dat;
        @(negedge clk);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic replay_trace;
        int                            fd;
        int                            n;
        int                            count;
        byte                           op;
        string                         rest;
        logic [img2col_pkg::adr_w-1:0] adr;
        logic [img2col_pkg::dat_w-1:0] value;
        logic [img2col_pkg::dat_w-1:0] rdat;
        fd = $fopen("img2col_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file img2col_trace.txt");
            $display("SOME TESTS FAILED");
            $fatal(1, "no trace file");
        end
        while ($fscanf(fd, " %c", op) == 1)
        begin
            if (op == "#")
            begin
                n = $fgets(rest, fd);
            end
            else if (op == "w")
            begin
                n = $fscanf(fd, " %h %d", adr, count);
                cycle_limit = cycle_limit + count * access_budget;
                for (int i = 0; i < count; i++)
                begin
                    n = $fscanf(fd, " %h", value);
                    bus_access(1'b1, adr + img2col_pkg::adr_w'(i), value, rdat);
                end
            end
            else if (op == "r")
            begin
                n = $fscanf(fd, " %h %h", adr, value);
                cycle_limit = cycle_limit + access_budget;
                bus_access(1'b0, adr, '0, rdat);
                assert (rdat === value)
                else
                begin
                    $display("error: wb_rsp.dat at adr %h is %h, expected %h", adr, rdat, value);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "read mismatch");
                end
            end
            else if (op == "p")
            begin
                cycle_limit = cycle_limit + poll_budget;
                rdat = '0;
                while (rdat[0] !== 1'b1)
                begin
                    bus_access(1'b0, img2col_pkg::adr_stat, '0, rdat);
                end
            end
            else
            begin
                $display("The trace holds an unknown operation '%c'", op);
                $display("SOME TESTS FAILED");
                $fatal(1, "bad trace");
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        nrst        = 1'b0;
        wb_req      = '0;
        cycle_limit = reset_cycles + 4;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        replay_trace();
        if (UUT.u_loader.u_chk.fail_count == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== img2col_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module img2col_chk (
    input  logic clk,
    input  logic nrst,
    input  logic ack,
    input  logic cyc,
    input  logic stb,
    input  logic col_done,
    input  logic window_valid,
    input  logic sum_valid
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (!nrst) ack |-> cyc && stb)
        else
        begin
            fail_count = fail_count + 1;
            $error("ack outside an active bus cycle");
        end

    assert property (@(posedge clk) disable iff (!nrst) ack |=> !ack)
        else
        begin
            fail_count = fail_count + 1;
            $error("ack held for more than one cycle");
        end

    assert property (@(posedge clk) disable iff (!nrst) window_valid |-> $past(col_done))
        else
        begin
            fail_count = fail_count + 1;
            $error("window_valid without col_done the cycle before");
        end

    assert property (@(posedge clk) disable iff (!nrst) window_valid |=> !window_valid)
        else
        begin
            fail_count = fail_count + 1;
            $error("window_valid longer than one cycle");
        end

    // The MAC has two register stages.
    assert property (@(posedge clk) disable iff (!nrst) sum_valid == $past(window_valid, 2))
        else
        begin
            fail_count = fail_count + 1;
            $error("sum_valid does not trail window_valid by two cycles");
        end

endmodule

bind pixel_loader img2col_chk u_chk (
    .clk          (clk),
    .nrst         (nrst),
    .ack          (wb_rsp.ack),
    .cyc          (wb_req.cyc),
    .stb          (wb_req.stb),
    .col_done     (col_done),
    .window_valid (window_valid),
    .sum_valid    (sum_valid)
);

`default_nettype wire

// ==== img2col_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module img2col_top (
    input  logic                 clk,
    input  logic                 nrst,
    input  img2col_pkg::wb_req_t wb_req,
    output img2col_pkg::wb_rsp_t wb_rsp
);

    img2col_pkg::window_t                 pix_buf;
    img2col_pkg::weights_t                weights;
    img2col_pkg::window_t                 win;
    logic                                 start;
    logic                                 col_done;
    logic                                 first_row;
    logic                                 window_valid;
    logic signed [img2col_pkg::acc_w-1:0] sum;
    logic                                 sum_valid;

    pixel_loader u_loader (
        .clk          (clk),
        .nrst         (nrst),
        .wb_req       (wb_req),
        .window_valid (window_valid),
        .sum          (sum),
        .sum_valid    (sum_valid),
        .wb_rsp       (wb_rsp),
        .pix_buf      (pix_buf),
        .weights      (weights),
        .start        (start),
        .col_done     (col_done),
        .first_row    (first_row)
    );

    window_ctrl u_ctrl (
        .clk          (clk),
        .nrst         (nrst),
        .pix_buf      (pix_buf),
        .start        (start),
        .col_done     (col_done),
        .first_row    (first_row),
        .win          (win),
        .window_valid (window_valid)
    );

    window_mac u_mac (
        .clk          (clk),
        .nrst         (nrst),
        .win          (win),
        .weights      (weights),
        .window_valid (window_valid),
        .sum          (sum),
        .sum_valid    (sum_valid)
    );

endmodule

`default_nettype wire

// ==== window_mac.sv ====
`timescale 1ns/1ns
`default_nettype none

module window_mac (
    input  logic                                 clk,
    input  logic                                 nrst,
    input  img2col_pkg::window_t                 win,
    input  img2col_pkg::weights_t                weights,
    input  logic                                 window_valid,
    output logic signed [img2col_pkg::acc_w-1:0] sum,
    output logic                                 sum_valid
);

    logic [img2col_pkg::win_n-1:0][img2col_pkg::prod_w-1:0] prod_q;
    logic                                                   prod_valid_q;

    // Balanced tree over 32 leaves, node n adds nodes 2n and 2n+1.
    function automatic logic signed [img2col_pkg::acc_w-1:0] tree_sum(
        input logic [img2col_pkg::win_n-1:0][img2col_pkg::prod_w-1:0] p
    );
        logic signed [img2col_pkg::acc_w-1:0] node [1:2*img2col_pkg::tree_n-1];
        for (int i = 0; i < img2col_pkg::win_n; i++)
        begin
            node[img2col_pkg::tree_n + i] = img2col_pkg::acc_w'($signed(p[i]));
        end
        for (int i = img2col_pkg::win_n; i < img2col_pkg::tree_n; i++)
        begin
            node[img2col_pkg::tree_n + i] = '0;     // Padding leaves.
        end
        for (int n = img2col_pkg::tree_n - 1; n >= 1; n--)
        begin
            node[n] = node[2*n] + node[2*n + 1];
        end
        return node[1];
    endfunction

    always_ff @(posedge clk)
    begin
        if (window_valid)
        begin
            for (int i = 0; i < img2col_pkg::win_n; i++)
            begin
                // Pixel gets a zero sign bit so the multiply is signed.
                prod_q[i] <= $signed({1'b0, win[i]}) * $signed(weights[i]);
            end
        end
        if (prod_valid_q)
        begin
            sum <= tree_sum(prod_q);
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            prod_valid_q <= 1'b0;
            sum_valid    <= 1'b0;
        end
        else
        begin
            prod_valid_q <= window_valid;
            sum_valid    <= prod_valid_q;
        end
    end

endmodule

`default_nettype wire

// ==== window_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module window_ctrl (
    input  logic                  clk,
    input  logic                  nrst,
    input  img2col_pkg::window_t  pix_buf,
    input  logic                  start,
    input  logic                  col_done,
    input  logic                  first_row,
    output img2col_pkg::window_t  win,
    output logic                  window_valid
);

    img2col_pkg::win_state_t state_q;
    img2col_pkg::win_state_t state_d;

    // Reuse bank, element i of the next window for i below 20.
    logic [img2col_pkg::reuse_n-1:0][img2col_pkg::pix_w-1:0] reuse_q;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            state_q <= img2col_pkg::idle;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            img2col_pkg::idle:
            begin
                if (start)
                begin
                    state_d = img2col_pkg::load;
                end
            end
            img2col_pkg::load:
            begin
                if (col_done)
                begin
                    state_d = img2col_pkg::emit;    // Last pixel of the column is in.
                end
            end
            img2col_pkg::emit:
            begin
                state_d = img2col_pkg::shift;
            end
            img2col_pkg::shift:
            begin
                state_d = img2col_pkg::load;
            end
            default:
            begin
                state_d = img2col_pkg::idle;
            end
        endcase
    end

    // The window is captured on the way into emit, so it is stable while valid.
    always_ff @(posedge clk)
    begin
        if ((state_q == img2col_pkg::load) && col_done)
        begin
            if (first_row)
            begin
                win <= pix_buf;
            end
            else
            begin
                win <= {pix_buf[img2col_pkg::win_n-1:img2col_pkg::reuse_n], reuse_q};
            end
        end
    end

    // The newest four columns of the window become the next reuse bank.
    // After a full window that is buffer entries 5 to 24, otherwise the
    // bank's own entries 5 to 19 and the new column. Taking them from win
    // keeps the bank safe from buffer writes that land during emit.
    always_ff @(posedge clk)
    begin
        if (state_q == img2col_pkg::shift)
        begin
            reuse_q <= win[img2col_pkg::win_n-1:img2col_pkg::col_n];
        end
    end

    assign window_valid = state_q == img2col_pkg::emit;

endmodule

`default_nettype wire

// ==== pixel_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_loader (
    input  logic                                clk,
    input  logic                                nrst,
    input  img2col_pkg::wb_req_t                wb_req,
    input  logic                                window_valid,
    input  logic signed [img2col_pkg::acc_w-1:0] sum,
    input  logic                                sum_valid,
    output img2col_pkg::wb_rsp_t                wb_rsp,
    output img2col_pkg::window_t                pix_buf,
    output img2col_pkg::weights_t               weights,
    output logic                                start,
    output logic                                col_done,
    output logic                                first_row
);

    logic                                 ack_q;
    logic [img2col_pkg::dat_w-1:0]        rdat_q;
    logic [img2col_pkg::dat_w-1:0]        rdat;
    logic                                 req;
    logic                                 wr;
    logic                                 rd;
    logic [img2col_pkg::adr_w-1:0]        pix_idx;
    logic [img2col_pkg::adr_w-1:0]        wgt_idx;
    logic                                 is_pix;
    logic                                 is_wgt;
    logic                                 is_ctrl;
    logic                                 is_res;
    logic signed [img2col_pkg::acc_w-1:0] res_q;
    logic                                 done_q;

    // A cycle that has already been acked is not taken again.
    assign req = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr  = req && wb_req.we;
    assign rd  = req && !wb_req.we;

    // Offsets wrap below the base, so one compare covers both bounds.
    assign pix_idx = wb_req.adr - img2col_pkg::adr_pix;
    assign wgt_idx = wb_req.adr - img2col_pkg::adr_wgt;
    assign is_pix  = pix_idx < img2col_pkg::adr_w'(img2col_pkg::win_n);
    assign is_wgt  = wgt_idx < img2col_pkg::adr_w'(img2col_pkg::win_n);
    assign is_ctrl = wb_req.adr == img2col_pkg::adr_ctrl;
    assign is_res  = wb_req.adr == img2col_pkg::adr_res;

    always_comb
    begin
        rdat = '0;                                  // Control and unmapped words read zero.
        if (is_pix)
        begin
            rdat = img2col_pkg::dat_w'(pix_buf[pix_idx[img2col_pkg::idx_w-1:0]]);
        end
        else if (is_wgt)
        begin
            rdat = img2col_pkg::dat_w'($signed(weights[wgt_idx[img2col_pkg::idx_w-1:0]]));
        end
        else if (wb_req.adr == img2col_pkg::adr_stat)
        begin
            rdat = img2col_pkg::dat_w'(done_q);
        end
        else if (is_res)
        begin
            rdat = img2col_pkg::dat_w'(res_q);      // Sign extended from the accumulator.
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            ack_q    <= 1'b0;
            start    <= 1'b0;
            col_done <= 1'b0;
        end
        else
        begin
            ack_q    <= req;
            start    <= wr && is_ctrl && wb_req.dat[img2col_pkg::ctrl_start];
            col_done <= wr && is_pix && (pix_idx == img2col_pkg::adr_w'(img2col_pkg::win_n - 1));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd)
        begin
            rdat_q <= rdat;
        end
        if (wr && is_pix)
        begin
            pix_buf[pix_idx[img2col_pkg::idx_w-1:0]] <= wb_req.dat[img2col_pkg::pix_w-1:0];
        end
        if (wr && is_wgt)
        begin
            weights[wgt_idx[img2col_pkg::idx_w-1:0]] <= wb_req.dat[img2col_pkg::wgt_w-1:0];
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            first_row <= 1'b0;
        end
        else if (wr && is_ctrl && wb_req.dat[img2col_pkg::ctrl_first])
        begin
            first_row <= 1'b1;
        end
        else if (window_valid)
        begin
            first_row <= 1'b0;                      // The full window has been taken.
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            res_q  <= '0;
            done_q <= 1'b0;
        end
        else if (sum_valid)
        begin
            res_q  <= sum;                          // A new sum wins over a clearing read.
            done_q <= 1'b1;
        end
        else if (rd && is_res)
        begin
            done_q <= 1'b0;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

endmodule

`default_nettype wire

// ==== img2col_pkg.sv ====
`default_nettype none

package img2col_pkg;

    localparam int pix_w   = 8;                    // Unsigned pixel.
    localparam int wgt_w   = 8;                    // Signed weight.
    localparam int prod_w  = pix_w + wgt_w + 1;    // Pixel is widened by a zero sign bit.
    localparam int acc_w   = 24;
    localparam int win_n   = 25;
    localparam int reuse_n = 20;                   // Four columns kept between windows.
    localparam int col_n   = 5;
    localparam int tree_n  = 32;                   // Adder tree leaves, padded to a power of two.
    localparam int idx_w   = 5;                    // Enough to index the 25 buffer entries.

    localparam int adr_w = 7;
    localparam int dat_w = 32;

    // Word addresses of the register map.
    localparam logic [adr_w-1:0] adr_pix  = 7'd0;
    localparam logic [adr_w-1:0] adr_wgt  = 7'd32;
    localparam logic [adr_w-1:0] adr_ctrl = 7'd64;
    localparam logic [adr_w-1:0] adr_stat = 7'd65;
    localparam logic [adr_w-1:0] adr_res  = 7'd66;

    localparam int ctrl_start = 0;                 // Control bit that starts the former.
    localparam int ctrl_first = 1;                 // Control bit that marks the first window.

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [adr_w-1:0] adr;
        logic [dat_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [dat_w-1:0] dat;
    } wb_rsp_t;

    // Element i holds buffer address i, so column c is elements 5c to 5c+4.
    typedef logic [win_n-1:0][pix_w-1:0] window_t;
    typedef logic [win_n-1:0][wgt_w-1:0] weights_t;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        load  = 2'd1,
        emit  = 2'd2,
        shift = 2'd3
    } win_state_t;

endpackage

`default_nettype wire
